/* neo_loader_pkg.sv */
package neo_loader_pkg;

	localparam int BANK3_ADDR_W = 24;
	localparam int SDR_ADDR_W   = 26;

	typedef logic [31:0]             size_t;
	typedef logic [BANK3_ADDR_W-1:0] bank3_addr_t;
	typedef logic [SDR_ADDR_W-1:0]   sdr_addr_t;

	// Header order, which is also the load order
	typedef enum logic [2:0] {
		REG_P,
		REG_S,
		REG_M,
		REG_V1,
		REG_V2,
		REG_C,
		REG_DONE
	} region_t;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_WAIT_ACK,
		WR_CHECK_END
	} wr_state_t;

	typedef enum logic [7:0] {
		IDX_SYSTEM        = 8'd0,
		IDX_CART          = 8'd1,
		IDX_CART_NO_ADPCM = 8'd2,
		IDX_BIOS          = 8'd3
	} dl_index_t;

	localparam int HEADER_BYTES    = 4096;
	localparam int SIZE_FIRST_BYTE = 4;  // PSize low byte
	localparam int SIZE_END_BYTE   = 28; // first byte past CSize

	localparam size_t P2_BASE = 32'h0010_0000;

	// Bank 3 prefixes
	localparam logic [4:0] PFX_SROM  = 5'b1111_1;
	localparam logic [7:0] PFX_LOROM = 8'b1101_1110;
	localparam logic [6:0] PFX_SFIX  = 7'b1110_100;
	localparam logic [5:0] PFX_SM1   = 6'b1110_11;
	localparam logic [4:0] PFX_FIX   = 5'b1110_0;
	localparam logic [4:0] PFX_MROM  = 5'b1111_0;

	// Next power of two at or above size, minus one
	function automatic size_t ceil_mask(input size_t size);
		size_t m;
		m = size - 32'd1;
		m = m | (m >> 1);
		m = m | (m >> 2);
		m = m | (m >> 4);
		m = m | (m >> 8);
		m = m | (m >> 16);
		if (size == '0)
			m = '0; // empty region
		return m;
	endfunction

endpackage

/* neo_header_capture.sv */
`timescale 1ns/1ps

module neo_header_capture (
	input  logic                  CLK_48M,
	input  logic                  rst_n,
	input  logic                  ioctl_downl,
	input  logic [7:0]            ioctl_index,
	input  logic                  ioctl_wr,
	input  logic [26:0]           ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	output logic                  sys_wr_stb,
	output logic                  data_wr_stb,
	output logic                  header_done,
	output logic [26:0]           data_addr,
	output logic [7:0]            data_byte,
	output logic                  no_adpcm,
	output neo_loader_pkg::size_t p_size,
	output neo_loader_pkg::size_t s_size,
	output neo_loader_pkg::size_t m_size,
	output neo_loader_pkg::size_t v1_size,
	output neo_loader_pkg::size_t v2_size,
	output neo_loader_pkg::size_t c_size,
	output neo_loader_pkg::size_t c_mask,
	output neo_loader_pkg::size_t v1_mask,
	output neo_loader_pkg::size_t v2_mask,
	output neo_loader_pkg::size_t p2_mask,
	output logic                  pcm_merged,
	output logic                  adpcm_en
);
	import neo_loader_pkg::*;

	dl_index_t idx;
	logic      sys_dl;
	logic      cart_dl;
	logic      in_header;
	logic      in_size_field;
	logic      last_header;

	assign idx     = dl_index_t'(ioctl_index);
	assign sys_dl  = ioctl_downl && (idx == IDX_SYSTEM || idx == IDX_BIOS);
	assign cart_dl = ioctl_downl && (idx == IDX_CART || idx == IDX_CART_NO_ADPCM);

	assign in_header     = ioctl_addr < 27'(HEADER_BYTES);
	assign in_size_field = ioctl_addr >= 27'(SIZE_FIRST_BYTE) &&
	                       ioctl_addr < 27'(SIZE_END_BYTE);
	assign last_header   = ioctl_addr == 27'(HEADER_BYTES - 1);

	// Bytes classified one cycle after ioctl_wr
	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			sys_wr_stb  <= 1'b0;
			data_wr_stb <= 1'b0;
			header_done <= 1'b0;
		end else begin
			sys_wr_stb  <= ioctl_wr & sys_dl;
			data_wr_stb <= ioctl_wr & cart_dl & ~in_header;
			header_done <= ioctl_wr & cart_dl & last_header;
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (ioctl_wr) begin
			data_addr <= ioctl_addr;
			data_byte <= ioctl_dout;
		end
	end

	// Little-endian sizes shift in from the top so P ends up lowest
	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			p_size   <= '0;
			s_size   <= '0;
			m_size   <= '0;
			v1_size  <= '0;
			v2_size  <= '0;
			c_size   <= '0;
			no_adpcm <= 1'b0;
		end else if (ioctl_wr && cart_dl) begin
			no_adpcm <= idx == IDX_CART_NO_ADPCM;
			if (in_size_field)
				{c_size, v2_size, v1_size, m_size, s_size, p_size} <=
					{ioctl_dout, c_size, v2_size, v1_size, m_size, s_size, p_size[31:8]};
		end
	end

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			c_mask     <= '0;
			v1_mask    <= '0;
			v2_mask    <= '0;
			p2_mask    <= '0;
			pcm_merged <= 1'b0;
			adpcm_en   <= 1'b1;
		end else if (header_done) begin
			c_mask     <= ceil_mask(c_size);
			v1_mask    <= ceil_mask(v1_size);
			v2_mask    <= ceil_mask(v2_size);
			p2_mask    <= (p_size > P2_BASE) ? ceil_mask(p_size - P2_BASE) : '0;
			pcm_merged <= v2_size == '0; // ADPCM-A and -B share V1
			adpcm_en   <= ~no_adpcm;
		end
	end

endmodule

/* neo_region_mapper.sv */
`timescale 1ns/1ps

module neo_region_mapper (
	input  logic                        CLK_48M,
	input  logic                        rst_n,
	input  logic                        sys_wr_stb,
	input  logic                        data_wr_stb,
	input  logic                        header_done,
	input  logic [26:0]                 data_addr,
	input  logic [7:0]                  data_byte,
	input  logic                        no_adpcm,
	input  neo_loader_pkg::size_t       p_size,
	input  neo_loader_pkg::size_t       s_size,
	input  neo_loader_pkg::size_t       m_size,
	input  neo_loader_pkg::size_t       v1_size,
	input  neo_loader_pkg::size_t       v2_size,
	input  neo_loader_pkg::size_t       c_size,
	input  logic                        port1_idle,
	input  logic                        port2_idle,
	output logic                        port1_start,
	output neo_loader_pkg::bank3_addr_t port1_addr,
	output logic                        port2_start,
	output neo_loader_pkg::sdr_addr_t   port2_addr,
	output logic [7:0]                  wr_byte,
	output logic                        busy
);
	import neo_loader_pkg::*;

	region_t     region;
	wr_state_t   wr_state;
	logic [25:0] offset;
	logic [25:0] region_size;
	logic        on_port1;
	logic        on_port2;
	logic        ack_done;
	bank3_addr_t sys_addr;
	bank3_addr_t cart_p1_addr;

	always_comb begin
		case (region)
			REG_P:   region_size = p_size[25:0];
			REG_S:   region_size = s_size[25:0];
			REG_M:   region_size = m_size[25:0];
			REG_V1:  region_size = v1_size[25:0];
			REG_V2:  region_size = v2_size[25:0];
			REG_C:   region_size = c_size[25:0];
			default: region_size = '0;
		endcase
	end

	assign on_port1 = region == REG_P || region == REG_S || region == REG_M;
	assign on_port2 = region == REG_C ||
	                  ((region == REG_V1 || region == REG_V2) && !no_adpcm);

	// Skipped bytes leave port 2 idle, so they pass straight through
	assign ack_done = on_port1 ? port1_idle : port2_idle;

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			region   <= REG_P;
			offset   <= '0;
			wr_state <= WR_IDLE;
		end else if (header_done) begin
			region   <= REG_P;
			offset   <= '0;
			wr_state <= WR_CHECK_END; // skip empty leading regions
		end else begin
			case (wr_state)
				WR_IDLE:
					if (data_wr_stb)
						wr_state <= WR_WAIT_ACK;
				WR_WAIT_ACK:
					if (ack_done) begin
						offset   <= offset + 26'd1;
						wr_state <= WR_CHECK_END;
					end
				WR_CHECK_END:
					if (region != REG_DONE && offset == region_size) begin
						offset <= '0;
						region <= region_t'(region + 3'd1);
					end else begin
						wr_state <= WR_IDLE;
					end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// System ROM, LO ROM, SFIX or SM1 by address range
	always_comb begin
		if (data_addr[23:19] == 5'd0)
			sys_addr = {PFX_SROM, data_addr[18:0]};
		else if (data_addr[23:17] == 7'b0000100)
			sys_addr = {PFX_LOROM, data_addr[15:0]};
		else if (data_addr[23:17] == 7'b0000101)
			sys_addr = {PFX_SFIX, data_addr[16:5], data_addr[2:0], ~data_addr[4], data_addr[3]};
		else
			sys_addr = {PFX_SM1, data_addr[17:0]};
	end

	always_comb begin
		case (region)
			REG_S:   cart_p1_addr = {PFX_FIX, offset[18:5], offset[2:0], ~offset[4], offset[3]};
			REG_M:   cart_p1_addr = {PFX_MROM, offset[18:0]};
			default: cart_p1_addr = offset[23:0]; // P ROM
		endcase
	end

	always_comb begin
		case (region)
			REG_V1:  port2_addr = c_size[25:0] + offset;
			REG_V2:  port2_addr = c_size[25:0] + v1_size[25:0] + offset;
			default: port2_addr = {offset[25:7], data_addr[5:2], ~data_addr[6],
			                      data_addr[0], data_addr[1]}; // C ROM interleave
		endcase
	end

	assign port1_addr  = sys_wr_stb ? sys_addr : cart_p1_addr;
	assign port1_start = port1_idle && (sys_wr_stb || (data_wr_stb && on_port1));
	assign port2_start = port2_idle && data_wr_stb && on_port2;
	assign wr_byte     = data_byte;

	// System bytes hold busy through their port 1 ack
	assign busy = wr_state != WR_IDLE || !port1_idle || !port2_idle;

endmodule

/* neo_sdram_write_port.sv */
`timescale 1ns/1ps

module neo_sdram_write_port #(
	parameter int ADDR_W = 24
) (
	input  logic              CLK_48M,
	input  logic              rst_n,
	input  logic              start,
	input  logic [ADDR_W-1:0] addr,
	input  logic [7:0]        byte_in,
	input  logic              ack,
	output logic              req,
	output logic [ADDR_W-2:0] sdr_addr,
	output logic [1:0]        ds,
	output logic [15:0]       d,
	output logic              idle
);

	assign idle = req == ack;

	always_ff @(posedge CLK_48M) begin
		if (!rst_n) begin
			req      <= 1'b0;
			sdr_addr <= '0;
			ds       <= 2'b00;
			d        <= '0;
		end else if (start && idle) begin
			req      <= ~req;
			sdr_addr <= addr[ADDR_W-1:1];
			ds       <= addr[0] ? 2'b10 : 2'b01;
			d        <= {byte_in, byte_in};
		end
	end

endmodule

/* neo_cart_loader.sv */
`timescale 1ns/1ps

module neo_cart_loader (
	input  logic                  CLK_48M,
	input  logic                  rst_n,
	input  logic                  ioctl_downl,
	input  logic [7:0]            ioctl_index,
	input  logic                  ioctl_wr,
	input  logic [26:0]           ioctl_addr,
	input  logic [7:0]            ioctl_dout,
	input  logic                  port1_ack,
	input  logic                  port2_ack,
	output logic                  port1_req,
	output logic [22:0]           port1_a,
	output logic [1:0]            port1_ds,
	output logic [15:0]           port1_d,
	output logic                  port2_req,
	output logic [24:0]           port2_a,
	output logic [1:0]            port2_ds,
	output logic [15:0]           port2_d,
	output logic                  busy,
	output neo_loader_pkg::size_t c_mask,
	output neo_loader_pkg::size_t v1_mask,
	output neo_loader_pkg::size_t v2_mask,
	output neo_loader_pkg::size_t p2_mask,
	output logic                  pcm_merged,
	output logic                  adpcm_en
);
	import neo_loader_pkg::*;

	logic        sys_wr_stb;
	logic        data_wr_stb;
	logic        header_done;
	logic [26:0] data_addr;
	logic [7:0]  data_byte;
	logic        no_adpcm;
	size_t       p_size;
	size_t       s_size;
	size_t       m_size;
	size_t       v1_size;
	size_t       v2_size;
	size_t       c_size;
	logic        port1_start;
	logic        port2_start;
	bank3_addr_t port1_addr;
	sdr_addr_t   port2_addr;
	logic [7:0]  wr_byte;
	logic        port1_idle;
	logic        port2_idle;

	neo_header_capture capture0 (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.ioctl_downl (ioctl_downl),
		.ioctl_index (ioctl_index),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.sys_wr_stb  (sys_wr_stb),
		.data_wr_stb (data_wr_stb),
		.header_done (header_done),
		.data_addr   (data_addr),
		.data_byte   (data_byte),
		.no_adpcm    (no_adpcm),
		.p_size      (p_size),
		.s_size      (s_size),
		.m_size      (m_size),
		.v1_size     (v1_size),
		.v2_size     (v2_size),
		.c_size      (c_size),
		.c_mask      (c_mask),
		.v1_mask     (v1_mask),
		.v2_mask     (v2_mask),
		.p2_mask     (p2_mask),
		.pcm_merged  (pcm_merged),
		.adpcm_en    (adpcm_en)
	);

	neo_region_mapper mapper0 (
		.CLK_48M     (CLK_48M),
		.rst_n       (rst_n),
		.sys_wr_stb  (sys_wr_stb),
		.data_wr_stb (data_wr_stb),
		.header_done (header_done),
		.data_addr   (data_addr),
		.data_byte   (data_byte),
		.no_adpcm    (no_adpcm),
		.p_size      (p_size),
		.s_size      (s_size),
		.m_size      (m_size),
		.v1_size     (v1_size),
		.v2_size     (v2_size),
		.c_size      (c_size),
		.port1_idle  (port1_idle),
		.port2_idle  (port2_idle),
		.port1_start (port1_start),
		.port1_addr  (port1_addr),
		.port2_start (port2_start),
		.port2_addr  (port2_addr),
		.wr_byte     (wr_byte),
		.busy        (busy)
	);

	// Bank 3
	neo_sdram_write_port #(.ADDR_W(BANK3_ADDR_W)) port1 (
		.CLK_48M  (CLK_48M),
		.rst_n    (rst_n),
		.start    (port1_start),
		.addr     (port1_addr),
		.byte_in  (wr_byte),
		.ack      (port1_ack),
		.req      (port1_req),
		.sdr_addr (port1_a),
		.ds       (port1_ds),
		.d        (port1_d),
		.idle     (port1_idle)
	);

	// Banks 0-2
	neo_sdram_write_port #(.ADDR_W(SDR_ADDR_W)) port2 (
		.CLK_48M  (CLK_48M),
		.rst_n    (rst_n),
		.start    (port2_start),
		.addr     (port2_addr),
		.byte_in  (wr_byte),
		.ack      (port2_ack),
		.req      (port2_req),
		.sdr_addr (port2_a),
		.ds       (port2_ds),
		.d        (port2_d),
		.idle     (port2_idle)
	);

endmodule

/* neo_cart_loader_tb.sv */
`timescale 1ns/1ps

module neo_cart_loader_tb;
	import neo_loader_pkg::*;

	localparam int NUM_ROWS = 6;
	localparam int NUM_SYS  = 8;

	logic        CLK_48M;
	logic        rst_n;
	logic        ioctl_downl;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [26:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        port1_ack = 1'b0;
	logic        port2_ack = 1'b0;
	logic        port1_req;
	logic [22:0] port1_a;
	logic [1:0]  port1_ds;
	logic [15:0] port1_d;
	logic        port2_req;
	logic [24:0] port2_a;
	logic [1:0]  port2_ds;
	logic [15:0] port2_d;
	logic        busy;
	size_t       c_mask;
	size_t       v1_mask;
	size_t       v2_mask;
	size_t       p2_mask;
	logic        pcm_merged;
	logic        adpcm_en;

	// Stimulus table with sizes in header order P S M V1 V2 C
	logic [7:0]  row_index [NUM_ROWS];
	logic [31:0] row_size [NUM_ROWS][6];
	bit          row_hdr_only [NUM_ROWS];
	string       row_label [NUM_ROWS];
	logic [26:0] sys_addr_list [NUM_SYS];

	logic [63:0] exp_q[$];
	logic [63:0] got_q[$];
	logic [31:0] lcg_state;
	int          p1_wait;
	int          p2_wait;
	int          byte_count = 0;
	int          errors = 0;
	int          checks = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	neo_cart_loader dut0 (.*);

	initial CLK_48M = 1'b0;
	always #2 CLK_48M = ~CLK_48M;

	always @(posedge CLK_48M) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [63:0] pack_wr(input int port, input logic [24:0] a,
			input logic [1:0] ds, input logic [15:0] d);
		return {19'd0, 2'(port), a, ds, d};
	endfunction

	// SDRAM model acks each request after 1 to 4 cycles
	always @(negedge CLK_48M) begin
		if (!rst_n) begin
			lcg_state = 32'heb80_c770;
			p1_wait   = 0;
			p2_wait   = 0;
			port1_ack <= 1'b0;
			port2_ack <= 1'b0;
		end else begin
			if (p1_wait > 0) begin
				p1_wait--;
				if (p1_wait == 0)
					port1_ack <= port1_req;
			end else if (port1_req != port1_ack) begin
				got_q.push_back(pack_wr(1, 25'(port1_a), port1_ds, port1_d));
				lcg_state = lcg_next(lcg_state);
				p1_wait   = lcg_state[17:16] + 1;
			end
			if (p2_wait > 0) begin
				p2_wait--;
				if (p2_wait == 0)
					port2_ack <= port2_req;
			end else if (port2_req != port2_ack) begin
				got_q.push_back(pack_wr(2, port2_a, port2_ds, port2_d));
				lcg_state = lcg_next(lcg_state);
				p2_wait   = lcg_state[17:16] + 1;
			end
		end
	end

	// Next power of two at or above size, less one
	function automatic logic [31:0] pow2_mask(input logic [31:0] size);
		logic [32:0] p;
		p = 33'd1;
		while (p < size)
			p = p << 1;
		return (size == 0) ? 32'd0 : 32'(p - 33'd1);
	endfunction

	// Low five bits of a FIX tile address
	function automatic logic [31:0] fix_swizzle(input logic [31:0] v);
		return ((v & 32'h7) << 2) | ((((v >> 4) & 32'h1) ^ 32'h1) << 1) | ((v >> 3) & 32'h1);
	endfunction

	task automatic set_row(input int row, input logic [7:0] idx, input logic [31:0] p,
			input logic [31:0] s, input logic [31:0] m, input logic [31:0] v1,
			input logic [31:0] v2, input logic [31:0] c, input bit hdr_only, input string label);
		row_index[row]    = idx;
		row_size[row][0]  = p;
		row_size[row][1]  = s;
		row_size[row][2]  = m;
		row_size[row][3]  = v1;
		row_size[row][4]  = v2;
		row_size[row][5]  = c;
		row_hdr_only[row] = hdr_only;
		row_label[row]    = label;
	endtask

	task automatic compare_value(input string name, input logic [63:0] exp,
			input logic [63:0] got);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
			errors++;
		end
	endtask

	task automatic expect_wr(input int port, input logic [31:0] byte_addr, input logic [7:0] b);
		exp_q.push_back(pack_wr(port, byte_addr[25:1], byte_addr[0] ? 2'b10 : 2'b01, {b, b}));
	endtask

	task automatic expect_cart(input int row, input int r, input logic [31:0] o,
			input logic [26:0] a, input logic [7:0] b);
		logic [31:0] aw;
		logic [31:0] c_sz;
		aw   = 32'(a);
		c_sz = row_size[row][5];
		case (r)
			0: expect_wr(1, o, b);
			1: expect_wr(1, 32'hE0_0000 | (o & 32'h7_FFE0) | fix_swizzle(o), b);
			2: expect_wr(1, 32'hF0_0000 | (o & 32'h7_FFFF), b);
			3: if (row_index[row] != 8'd2)
				expect_wr(2, c_sz + o, b);
			4: if (row_index[row] != 8'd2)
				expect_wr(2, c_sz + row_size[row][3] + o, b);
			default: expect_wr(2, (o & ~32'h7F) | (((aw >> 2) & 32'hF) << 3) |
				((((aw >> 6) & 32'h1) ^ 32'h1) << 2) | ((aw & 32'h1) << 1) |
				((aw >> 1) & 32'h1), b);
		endcase
	endtask

	task automatic expect_sys(input logic [26:0] a, input logic [7:0] b);
		logic [31:0] aw;
		aw = 32'(a);
		if (a < 27'h08_0000)
			expect_wr(1, 32'hF8_0000 | (aw & 32'h7_FFFF), b); // system ROM
		else if (a < 27'h0A_0000)
			expect_wr(1, 32'hDE_0000 | (aw & 32'hFFFF), b);
		else if (a < 27'h0C_0000)
			expect_wr(1, 32'hE8_0000 | (aw & 32'h1_FFE0) | fix_swizzle(aw), b);
		else
			expect_wr(1, 32'hEC_0000 | (aw & 32'h3_FFFF), b); // SM1
	endtask

	task automatic wait_ready();
		while (busy)
			@(negedge CLK_48M);
	endtask

	task automatic send_data(input logic [26:0] addr, input logic [7:0] value);
		@(negedge CLK_48M);
		ioctl_addr <= addr;
		ioctl_dout <= value;
		ioctl_wr   <= 1'b1;
		@(negedge CLK_48M);
		ioctl_wr <= 1'b0;
		@(negedge CLK_48M); // busy is up by now
		wait_ready();
	endtask

	// Header bytes go back to back
	task automatic send_header(input int row);
		logic [31:0] sz;
		for (int i = 0; i < HEADER_BYTES; i++) begin
			@(negedge CLK_48M);
			ioctl_addr <= 27'(i);
			if (i >= 4 && i < 28) begin
				sz = row_size[row][(i - 4) / 4];
				ioctl_dout <= 8'(sz >> (8 * ((i - 4) % 4)));
			end else begin
				ioctl_dout <= 8'(i);
			end
			ioctl_wr <= 1'b1;
		end
		@(negedge CLK_48M);
		ioctl_wr <= 1'b0;
		@(negedge CLK_48M);
		wait_ready();
	endtask

	task automatic check_flags(input int row);
		logic [31:0] p_sz;
		p_sz = row_size[row][0];
		compare_value("c_mask", pow2_mask(row_size[row][5]), c_mask);
		compare_value("v1_mask", pow2_mask(row_size[row][3]), v1_mask);
		compare_value("v2_mask", pow2_mask(row_size[row][4]), v2_mask);
		compare_value("p2_mask", (p_sz > 32'h10_0000) ? pow2_mask(p_sz - 32'h10_0000) : 0,
			p2_mask);
		compare_value("pcm_merged", row_size[row][4] == 0, pcm_merged);
		compare_value("adpcm_en", row_index[row] != 8'd2, adpcm_en);
	endtask

	task automatic load_cart(input int row);
		logic [26:0] a;
		a = 27'(HEADER_BYTES);
		for (int r = 0; r < 6; r++) begin
			for (int off = 0; off < row_size[row][r]; off++) begin
				expect_cart(row, r, 32'(off), a, 8'(byte_count));
				send_data(a, 8'(byte_count));
				byte_count++;
				a++;
			end
		end
	endtask

	task automatic compare_writes();
		logic [63:0] e;
		logic [63:0] g;
		checks++;
		assert (got_q.size() == exp_q.size()) else begin
			$display("Wrong number of SDRAM requests: expected %0d, saw %0d",
				exp_q.size(), got_q.size());
			errors++;
		end
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
			e = exp_q[i];
			g = got_q[i];
			compare_value($sformatf("port of write %0d", i), e[44:43], g[44:43]);
			compare_value($sformatf("port%0d_a (write %0d)", e[44:43], i), e[42:18], g[42:18]);
			compare_value($sformatf("port%0d_ds (write %0d)", e[44:43], i), e[17:16], g[17:16]);
			compare_value($sformatf("port%0d_d (write %0d)", e[44:43], i), e[15:0], g[15:0]);
		end
		exp_q.delete();
		got_q.delete();
	endtask

	initial begin
		int err_before;
		int bytes;
		set_row(0, 8'd1, 6, 8, 3, 5, 4, 9, 1'b0, "full cart");
		set_row(1, 8'd1, 0, 5, 0, 3, 0, 7, 1'b0, "empty regions");
		set_row(2, 8'd2, 3, 2, 2, 4, 3, 4, 1'b0, "no ADPCM");
		set_row(3, 8'd1, 32'h18_0000, 32'h2_0000, 32'h1_0000, 32'h30_0000, 0, 32'h80_0000,
			1'b1, "large header");
		set_row(4, 8'd0, 0, 0, 0, 0, 0, 0, 1'b0, "system ROM");
		set_row(5, 8'd3, 0, 0, 0, 0, 0, 0, 1'b0, "BIOS");
		sys_addr_list = '{27'h00_0010, 27'h07_FFF3, 27'h08_0123, 27'h09_ABCD,
			27'h0A_0031, 27'h0B_FFEE, 27'h0C_0005, 27'h0E_1234};

		for (int row = 0; row < NUM_ROWS; row++) begin
			bytes = NUM_SYS;
			if (row_index[row] == 8'd1 || row_index[row] == 8'd2) begin
				bytes = HEADER_BYTES;
				if (!row_hdr_only[row])
					for (int r = 0; r < 6; r++)
						bytes += row_size[row][r];
			end
			cycle_limit += bytes * 8 + 200;
		end

		rst_n       = 1'b0;
		ioctl_downl = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr    = 1'b0;
		ioctl_addr  = '0;
		ioctl_dout  = 8'd0;
		repeat (3) @(negedge CLK_48M);
		rst_n <= 1'b1;
		@(negedge CLK_48M);
		compare_value("port1_req", 0, port1_req);
		compare_value("port2_req", 0, port2_req);
		compare_value("busy", 0, busy);
		$display("Reset values: %0d errors", errors);

		for (int row = 0; row < NUM_ROWS; row++) begin
			err_before = errors;
			@(negedge CLK_48M);
			ioctl_index <= row_index[row];
			ioctl_downl <= 1'b1;
			if (row_index[row] == 8'd0 || row_index[row] == 8'd3) begin
				for (int i = 0; i < NUM_SYS; i++) begin
					expect_sys(sys_addr_list[i], 8'(byte_count));
					send_data(sys_addr_list[i], 8'(byte_count));
					byte_count++;
				end
			end else begin
				send_header(row);
				check_flags(row);
				if (!row_hdr_only[row])
					load_cart(row);
			end
			@(negedge CLK_48M);
			ioctl_downl <= 1'b0;
			compare_writes();
			$display("Row %0d (%s): %s, %0d errors", row, row_label[row],
				(errors == err_before) ? "pass" : "fail", errors - err_before);
		end

		$display("Rows: %0d, checks: %0d, errors: %0d", NUM_ROWS, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* neo_cart_loader.f */
neo_loader_pkg.sv
neo_header_capture.sv
neo_region_mapper.sv
neo_sdram_write_port.sv
neo_cart_loader.sv
neo_cart_loader_tb.sv
